/* src/alu.sv */
module alu (
	input cpu_ctrl_pkg::alu_ops aluop,
	input rv32i_isa_pkg::branch_funct3 cmpop,
	input logic [31:0] a,
	input logic [31:0] b,
	input logic [31:0] cmp_a,
	input logic [31:0] cmp_b,
	output logic [31:0] f,
	output logic br_en
);

	always_comb begin
		case (aluop)
			cpu_ctrl_pkg::alu_add: f = a + b;
			cpu_ctrl_pkg::alu_sub: f = a - b;
			cpu_ctrl_pkg::alu_sll: f = a << b[4:0];
			cpu_ctrl_pkg::alu_slt: f = {31'd0, $signed(a) < $signed(b)};
			cpu_ctrl_pkg::alu_sltu: f = {31'd0, a < b};
			cpu_ctrl_pkg::alu_xor: f = a ^ b;
			cpu_ctrl_pkg::alu_srl: f = a >> b[4:0];
			cpu_ctrl_pkg::alu_sra: f = $unsigned($signed(a) >>> b[4:0]);
			cpu_ctrl_pkg::alu_or: f = a | b;
			cpu_ctrl_pkg::alu_and: f = a & b;
			default: f = b;
		endcase
	end

	// Funct3 values outside the branch set never take
	always_comb begin
		case (cmpop)
			rv32i_isa_pkg::beq: br_en = (cmp_a == cmp_b);
			rv32i_isa_pkg::bne: br_en = (cmp_a != cmp_b);
			rv32i_isa_pkg::blt: br_en = ($signed(cmp_a) < $signed(cmp_b));
			rv32i_isa_pkg::bge: br_en = ($signed(cmp_a) >= $signed(cmp_b));
			rv32i_isa_pkg::bltu: br_en = (cmp_a < cmp_b);
			rv32i_isa_pkg::bgeu: br_en = (cmp_a >= cmp_b);
			default: br_en = 1'b0;
		endcase
	end

endmodule

/* src/cpu_control.sv */
module cpu_control (
	input logic [rv32i_isa_pkg::ilen-1:0] instr,
	output rv32i_isa_pkg::rv32i_opcode opcode,
	output logic [2:0] funct3,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [31:0] imm,
	output cpu_ctrl_pkg::alu_ops aluop,
	output cpu_ctrl_pkg::alu_src_a src_a,
	output cpu_ctrl_pkg::alu_src_b src_b,
	output cpu_ctrl_pkg::wb_sel wb,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic branch,
	output logic jump,
	output logic uses_rs2
);

	logic [31:0] i_imm, s_imm, b_imm, u_imm, j_imm;
	logic uses_rs1;

	function automatic cpu_ctrl_pkg::alu_ops alu_decode(input logic [2:0] f3, input logic alt,
			input logic is_reg);
		case (f3)
			3'b000: return (alt && is_reg) ? cpu_ctrl_pkg::alu_sub : cpu_ctrl_pkg::alu_add;
			3'b001: return cpu_ctrl_pkg::alu_sll;
			3'b010: return cpu_ctrl_pkg::alu_slt;
			3'b011: return cpu_ctrl_pkg::alu_sltu;
			3'b100: return cpu_ctrl_pkg::alu_xor;
			3'b101: return alt ? cpu_ctrl_pkg::alu_sra : cpu_ctrl_pkg::alu_srl;
			3'b110: return cpu_ctrl_pkg::alu_or;
			default: return cpu_ctrl_pkg::alu_and;
		endcase
	endfunction

	assign opcode = rv32i_isa_pkg::rv32i_opcode'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign rd = instr[11:7];
	assign rs2 = instr[24:20];
	// LUI and JAL carry no rs1, keep them out of hazard checks
	assign rs1 = uses_rs1 ? instr[19:15] : 5'd0;

	assign i_imm = {{21{instr[31]}}, instr[30:20]};
	assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
	assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
	assign u_imm = {instr[31:12], 12'h000};
	assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = i_imm;
		aluop = cpu_ctrl_pkg::alu_add;
		src_a = cpu_ctrl_pkg::a_rs1;
		src_b = cpu_ctrl_pkg::b_imm;
		wb = cpu_ctrl_pkg::wb_alu;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		jump = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		case (opcode)
			rv32i_isa_pkg::op_lui: begin
				imm = u_imm;
				aluop = cpu_ctrl_pkg::alu_pass_b;
				src_a = cpu_ctrl_pkg::a_zero;
				reg_write = 1'b1;
			end
			rv32i_isa_pkg::op_jal: begin
				imm = j_imm;
				src_a = cpu_ctrl_pkg::a_pc;
				wb = cpu_ctrl_pkg::wb_pc4;
				reg_write = 1'b1;
				jump = 1'b1;
			end
			rv32i_isa_pkg::op_jalr: begin
				wb = cpu_ctrl_pkg::wb_pc4;
				reg_write = 1'b1;
				jump = 1'b1;
				uses_rs1 = 1'b1;
			end
			rv32i_isa_pkg::op_br: begin
				// ALU forms the target, the comparator decides
				imm = b_imm;
				src_a = cpu_ctrl_pkg::a_pc;
				branch = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			rv32i_isa_pkg::op_load: begin
				wb = cpu_ctrl_pkg::wb_mem;
				reg_write = 1'b1;
				mem_read = 1'b1;
				uses_rs1 = 1'b1;
			end
			rv32i_isa_pkg::op_store: begin
				imm = s_imm;
				mem_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			rv32i_isa_pkg::op_imm: begin
				aluop = alu_decode(funct3, instr[30], 1'b0);
				reg_write = 1'b1;
				uses_rs1 = 1'b1;
			end
			rv32i_isa_pkg::op_reg: begin
				aluop = alu_decode(funct3, instr[30], 1'b1);
				src_b = cpu_ctrl_pkg::b_rs2;
				reg_write = 1'b1;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

/* src/cpu_ctrl_pkg.sv */
package cpu_ctrl_pkg;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_ops;

	typedef enum logic [1:0] {
		a_rs1,
		a_pc,
		a_zero
	} alu_src_a;

	typedef enum logic {
		b_rs2,
		b_imm
	} alu_src_b;

	typedef enum logic [1:0] {
		wb_alu,
		wb_mem,
		wb_pc4
	} wb_sel;

	// Operand source in execute
	typedef enum logic [1:0] {
		fwd_none,
		fwd_exmem,
		fwd_memwb
	} fwd_sel;

endpackage

/* src/cpu_datapath.sv */
module cpu_datapath #(
	parameter logic [31:0] reset_pc = 32'h0000_0000
) (
	input logic clk,
	input logic reset,
	input logic resp_a,
	input logic resp_b,
	input logic [31:0] rdata_a,
	input logic [31:0] rdata_b,
	output logic read_a,
	output logic read_b,
	output logic write,
	output logic [3:0] wmask,
	output logic [31:0] address_a,
	output logic [31:0] address_b,
	output logic [31:0] wdata
);

	localparam int w = rv32i_isa_pkg::xlen;

	logic advance, taken, stall, stall_lw, br_en, dmem_done;
	logic [w-1:0] pc, target, dmem_hold, rdata_mem, load_data, wb_data;
	// IF/ID
	logic ifid_valid;
	logic [w-1:0] ifid_instr, ifid_pc;
	// Decode
	logic [2:0] id_funct3;
	logic [4:0] id_rs1, id_rs2, id_rd;
	logic [w-1:0] id_imm, id_rs1_val, id_rs2_val;
	cpu_ctrl_pkg::alu_ops id_aluop, idex_aluop;
	cpu_ctrl_pkg::alu_src_a id_src_a, idex_src_a;
	cpu_ctrl_pkg::alu_src_b id_src_b, idex_src_b;
	cpu_ctrl_pkg::wb_sel id_wb, idex_wb, exmem_wb, memwb_wb;
	logic id_reg_write, id_mem_read, id_mem_write, id_branch, id_jump, id_uses_rs2;
	// ID/EX
	logic idex_valid, idex_reg_write, idex_mem_read, idex_mem_write, idex_branch, idex_jump;
	logic [2:0] idex_funct3;
	logic [4:0] idex_rs1, idex_rs2, idex_rd;
	logic [w-1:0] idex_pc, idex_imm, idex_rs1_val, idex_rs2_val;
	// Execute
	cpu_ctrl_pkg::fwd_sel fwd_a, fwd_b;
	logic [w-1:0] rs1_fwd, rs2_fwd, alu_a, alu_b, alu_f, ex_result;
	// EX/MEM and MEM/WB
	logic exmem_valid, exmem_reg_write, exmem_mem_read, exmem_mem_write;
	logic [2:0] exmem_funct3;
	logic [4:0] exmem_rd, memwb_rd;
	logic [w-1:0] exmem_result, exmem_rs2, memwb_result, memwb_load;
	logic memwb_valid, memwb_reg_write;

	assign read_a = 1'b1;
	assign address_a = pc;

	// Whole pipeline moves only when both ports are satisfied
	assign advance = resp_a && (!(read_b || write) || resp_b);
	assign stall = stall_lw && ifid_valid;
	assign taken = idex_valid && (idex_jump || (idex_branch && br_en));
	assign target = {alu_f[w-1:1], 1'b0};

	always_ff @(posedge clk) begin
		if (reset)
			pc <= reset_pc;
		else if (advance && taken)
			pc <= target;
		else if (advance && !stall)
			pc <= pc + 32'd4;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ifid_valid <= 1'b0;
		end else if (advance && (taken || !stall)) begin
			ifid_valid <= !taken;
			ifid_instr <= rdata_a;
			ifid_pc <= pc;
		end
	end

	cpu_control ctrl (
		.instr(ifid_instr),
		.opcode(),
		.funct3(id_funct3),
		.rs1(id_rs1),
		.rs2(id_rs2),
		.rd(id_rd),
		.imm(id_imm),
		.aluop(id_aluop),
		.src_a(id_src_a),
		.src_b(id_src_b),
		.wb(id_wb),
		.reg_write(id_reg_write),
		.mem_read(id_mem_read),
		.mem_write(id_mem_write),
		.branch(id_branch),
		.jump(id_jump),
		.uses_rs2(id_uses_rs2)
	);

	regfile regs (
		.clk,
		.reset,
		.load(memwb_valid && memwb_reg_write),
		.dest(memwb_rd),
		.src_a(id_rs1),
		.src_b(id_rs2),
		.in(wb_data),
		.reg_a(id_rs1_val),
		.reg_b(id_rs2_val)
	);

	forwarding_unit fwd (
		.id_rs1,
		.id_rs2,
		.ex_rs1(idex_rs1),
		.ex_rs2(idex_rs2),
		.exmem_rd,
		.memwb_rd,
		.exmem_reg_write(exmem_valid && exmem_reg_write),
		.memwb_reg_write(memwb_valid && memwb_reg_write),
		.ex_mem_read(idex_valid && idex_mem_read),
		.id_uses_rs2,
		.ex_rd(idex_rd),
		.fwd_a,
		.fwd_b,
		.stall_lw
	);

	// A stall or a flush leaves a bubble in execute
	always_ff @(posedge clk) begin
		if (reset) begin
			idex_valid <= 1'b0;
		end else if (advance) begin
			idex_valid <= ifid_valid && !taken && !stall;
			idex_pc <= ifid_pc;
			idex_imm <= id_imm;
			idex_rs1_val <= id_rs1_val;
			idex_rs2_val <= id_rs2_val;
			idex_rs1 <= id_rs1;
			idex_rs2 <= id_rs2;
			idex_rd <= id_rd;
			idex_funct3 <= id_funct3;
			idex_aluop <= id_aluop;
			idex_src_a <= id_src_a;
			idex_src_b <= id_src_b;
			idex_wb <= id_wb;
			idex_reg_write <= id_reg_write;
			idex_mem_read <= id_mem_read;
			idex_mem_write <= id_mem_write;
			idex_branch <= id_branch;
			idex_jump <= id_jump;
		end
	end

	always_comb begin
		case (fwd_a)
			cpu_ctrl_pkg::fwd_exmem: rs1_fwd = exmem_result;
			cpu_ctrl_pkg::fwd_memwb: rs1_fwd = wb_data;
			default: rs1_fwd = idex_rs1_val;
		endcase
		case (fwd_b)
			cpu_ctrl_pkg::fwd_exmem: rs2_fwd = exmem_result;
			cpu_ctrl_pkg::fwd_memwb: rs2_fwd = wb_data;
			default: rs2_fwd = idex_rs2_val;
		endcase
		case (idex_src_a)
			cpu_ctrl_pkg::a_pc: alu_a = idex_pc;
			cpu_ctrl_pkg::a_zero: alu_a = '0;
			default: alu_a = rs1_fwd;
		endcase
		alu_b = (idex_src_b == cpu_ctrl_pkg::b_imm) ? idex_imm : rs2_fwd;
	end

	alu alu (
		.aluop(idex_aluop),
		.cmpop(rv32i_isa_pkg::branch_funct3'(idex_funct3)),
		.a(alu_a),
		.b(alu_b),
		.cmp_a(rs1_fwd),
		.cmp_b(rs2_fwd),
		.f(alu_f),
		.br_en
	);

	// Jumps write the link while the ALU forms their target
	assign ex_result = (idex_wb == cpu_ctrl_pkg::wb_pc4) ? idex_pc + 32'd4 : alu_f;

	always_ff @(posedge clk) begin
		if (reset) begin
			exmem_valid <= 1'b0;
		end else if (advance) begin
			exmem_valid <= idex_valid;
			exmem_result <= ex_result;
			exmem_rs2 <= rs2_fwd;
			exmem_rd <= idex_rd;
			exmem_funct3 <= idex_funct3;
			exmem_wb <= idex_wb;
			exmem_reg_write <= idex_reg_write;
			exmem_mem_read <= idex_mem_read;
			exmem_mem_write <= idex_mem_write;
		end
	end

	// Data access finished while fetch still waits
	always_ff @(posedge clk) begin
		if (reset || advance)
			dmem_done <= 1'b0;
		else if ((read_b || write) && resp_b)
			dmem_done <= 1'b1;
	end

	always_ff @(posedge clk) begin
		if (read_b && resp_b)
			dmem_hold <= rdata_b;
	end

	assign rdata_mem = dmem_done ? dmem_hold : rdata_b;
	assign read_b = exmem_valid && exmem_mem_read && !dmem_done;
	assign write = exmem_valid && exmem_mem_write && !dmem_done;
	assign address_b = {exmem_result[w-1:2], 2'b00};

	mem_align align (
		.width(rv32i_isa_pkg::mem_width'(exmem_funct3)),
		.byte_off(exmem_result[1:0]),
		.store_data(exmem_rs2),
		.load_word(rdata_mem),
		.wdata,
		.wmask,
		.load_data
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			memwb_valid <= 1'b0;
		end else if (advance) begin
			memwb_valid <= exmem_valid;
			memwb_result <= exmem_result;
			memwb_load <= load_data;
			memwb_rd <= exmem_rd;
			memwb_wb <= exmem_wb;
			memwb_reg_write <= exmem_reg_write;
		end
	end

	assign wb_data = (memwb_wb == cpu_ctrl_pkg::wb_mem) ? memwb_load : memwb_result;

	assert property (@(posedge clk) disable iff (reset) !(read_b && write));

	assert property (@(posedge clk) disable iff (reset)
		(read_b || write) && !resp_b |=> $stable(read_b) && $stable(write) &&
			$stable(address_b) && $stable(wdata) && $stable(wmask));

endmodule

/* src/forwarding_unit.sv */
module forwarding_unit (
	input logic [4:0] id_rs1,
	input logic [4:0] id_rs2,
	input logic [4:0] ex_rs1,
	input logic [4:0] ex_rs2,
	input logic [4:0] exmem_rd,
	input logic [4:0] memwb_rd,
	input logic exmem_reg_write,
	input logic memwb_reg_write,
	input logic ex_mem_read,
	input logic id_uses_rs2,
	input logic [4:0] ex_rd,
	output cpu_ctrl_pkg::fwd_sel fwd_a,
	output cpu_ctrl_pkg::fwd_sel fwd_b,
	output logic stall_lw
);

	logic hit_rs1, hit_rs2;

	// Younger result in EX/MEM wins over MEM/WB
	function automatic cpu_ctrl_pkg::fwd_sel pick(input logic [4:0] src);
		if (src == 5'd0)
			return cpu_ctrl_pkg::fwd_none;
		if (exmem_reg_write && src == exmem_rd)
			return cpu_ctrl_pkg::fwd_exmem;
		if (memwb_reg_write && src == memwb_rd)
			return cpu_ctrl_pkg::fwd_memwb;
		return cpu_ctrl_pkg::fwd_none;
	endfunction

	always_comb begin
		fwd_a = pick(ex_rs1);
		fwd_b = pick(ex_rs2);
	end

	assign hit_rs1 = (id_rs1 != 5'd0) && (id_rs1 == ex_rd);
	assign hit_rs2 = id_uses_rs2 && (id_rs2 != 5'd0) && (id_rs2 == ex_rd);
	assign stall_lw = ex_mem_read && (hit_rs1 || hit_rs2);

endmodule

/* src/mem_align.sv */
module mem_align (
	input rv32i_isa_pkg::mem_width width,
	input logic [1:0] byte_off,
	input logic [31:0] store_data,
	input logic [31:0] load_word,
	output logic [31:0] wdata,
	output logic [3:0] wmask,
	output logic [31:0] load_data
);

	logic [31:0] shifted;

	// Addressed byte or half moved down to bit 0
	assign shifted = load_word >> {byte_off, 3'b000};

	always_comb begin
		case (width)
			rv32i_isa_pkg::w_byte, rv32i_isa_pkg::w_byte_u: begin
				wdata = {4{store_data[7:0]}};
				wmask = 4'b0001 << byte_off;
			end
			rv32i_isa_pkg::w_half, rv32i_isa_pkg::w_half_u: begin
				wdata = {2{store_data[15:0]}};
				wmask = 4'b0011 << {byte_off[1], 1'b0};
			end
			default: begin
				wdata = store_data;
				wmask = 4'b1111;
			end
		endcase
	end

	always_comb begin
		case (width)
			rv32i_isa_pkg::w_byte: load_data = {{24{shifted[7]}}, shifted[7:0]};
			rv32i_isa_pkg::w_byte_u: load_data = {24'd0, shifted[7:0]};
			rv32i_isa_pkg::w_half: load_data = {{16{shifted[15]}}, shifted[15:0]};
			rv32i_isa_pkg::w_half_u: load_data = {16'd0, shifted[15:0]};
			default: load_data = load_word;
		endcase
	end

endmodule

/* src/regfile.sv */
module regfile (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [4:0] dest,
	input logic [4:0] src_a,
	input logic [4:0] src_b,
	input logic [31:0] in,
	output logic [31:0] reg_a,
	output logic [31:0] reg_b
);

	logic [31:0] data [32];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				data[i] <= '0;
			end
		end else if (load && dest != 5'd0) begin
			data[dest] <= in;
		end
	end

	// Same-cycle write shows through to decode
	assign reg_a = (src_a == 5'd0) ? '0 : (load && src_a == dest) ? in : data[src_a];
	assign reg_b = (src_b == 5'd0) ? '0 : (load && src_b == dest) ? in : data[src_b];

endmodule

/* src/rv32i_isa_pkg.sv */
package rv32i_isa_pkg;

	localparam int xlen = 32;
	localparam int ilen = 32;

	// Major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		op_lui   = 7'b0110111,
		op_jal   = 7'b1101111,
		op_jalr  = 7'b1100111,
		op_br    = 7'b1100011,
		op_load  = 7'b0000011,
		op_store = 7'b0100011,
		op_imm   = 7'b0010011,
		op_reg   = 7'b0110011
	} rv32i_opcode;

	typedef enum logic [2:0] {
		beq  = 3'b000,
		bne  = 3'b001,
		blt  = 3'b100,
		bge  = 3'b101,
		bltu = 3'b110,
		bgeu = 3'b111
	} branch_funct3;

	// Load and store width from funct3
	typedef enum logic [2:0] {
		w_byte   = 3'b000,
		w_half   = 3'b001,
		w_word   = 3'b010,
		w_byte_u = 3'b100,
		w_half_u = 3'b101
	} mem_width;

endpackage

/* tb.f */
src/rv32i_isa_pkg.sv
src/cpu_ctrl_pkg.sv
src/cpu_control.sv
src/regfile.sv
src/alu.sv
src/forwarding_unit.sv
src/mem_align.sv
src/cpu_datapath.sv
verif/cpu_tb.sv

/* verif/cpu_tb.sv */
module cpu_tb;

	localparam logic [31:0] start_pc = 32'h0000_0000;
	localparam logic [31:0] dmem_base = 32'h0000_0200;
	// Word index in program_cases.mem where the store count sits
	localparam int store_list = 'ha0;
	localparam int store_timeout = 500;

	logic clk = 1'b0;
	logic reset;
	logic resp_a;
	logic resp_b;
	logic [31:0] rdata_a;
	logic [31:0] rdata_b;
	logic read_a;
	logic read_b;
	logic write;
	logic [3:0] wmask;
	logic [31:0] address_a;
	logic [31:0] address_b;
	logic [31:0] wdata;

	logic [31:0] cases_mem [0:255];
	logic [31:0] imem [0:127];
	logic [31:0] dmem [0:63];
	integer seed;
	int wait_a;
	int wait_b;
	int n_stores;
	int next_store;
	int idle;

	cpu_datapath #(.reset_pc(start_pc)) DUT (
		.clk(clk),
		.reset(reset),
		.resp_a(resp_a),
		.resp_b(resp_b),
		.rdata_a(rdata_a),
		.rdata_b(rdata_b),
		.read_a(read_a),
		.read_b(read_b),
		.write(write),
		.wmask(wmask),
		.address_a(address_a),
		.address_b(address_b),
		.wdata(wdata)
	);

	always #4 clk = ~clk;

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic give_up(input string why);
		$display("Error at time %0t: %s", $time, why);
		stop_run();
	endtask

	// Byte enables widened to a bit mask
	function automatic logic [31:0] lane_bits(input logic [3:0] m);
		return {{8{m[3]}}, {8{m[2]}}, {8{m[1]}}, {8{m[0]}}};
	endfunction

	// Read-only instruction memory with random latency
	task automatic serve_fetch();
		logic [31:0] idx;
		resp_a = 1'b0;
		if (read_a) begin
			idx = (address_a - start_pc) >> 2;
			if (idx > 127 || address_a[1:0] != 2'b00)
				give_up($sformatf("fetch from %h is outside the program", address_a));
			if (wait_a == 0) begin
				resp_a = 1'b1;
				rdata_a = imem[idx];
				wait_a = $unsigned($random(seed)) % 4;
			end else begin
				wait_a--;
			end
		end
	endtask

	// Data memory checks a granted store before applying it
	task automatic serve_data();
		logic [31:0] idx;
		logic [31:0] keep;
		int base;
		int b;
		resp_b = 1'b0;
		if (read_b || write) begin
			if (wait_b != 0) begin
				wait_b--;
			end else begin
				resp_b = 1'b1;
				wait_b = $unsigned($random(seed)) % 4;
				if (write) begin
					if (next_store >= n_stores)
						give_up($sformatf("unexpected store of %h to %h", wdata, address_b));
					base = store_list + 1 + 3 * next_store;
					check(address_b, cases_mem[base], $sformatf("store %0d address", next_store));
					check({28'd0, wmask}, cases_mem[base + 2],
						$sformatf("store %0d wmask", next_store));
					keep = lane_bits(cases_mem[base + 2][3:0]);
					check(wdata & keep, cases_mem[base + 1] & keep,
						$sformatf("store %0d data", next_store));
					next_store++;
					idle = 0;
				end
				idx = (address_b - dmem_base) >> 2;
				if (idx > 63)
					give_up($sformatf("data access at %h is outside data memory", address_b));
				if (write) begin
					for (b = 0; b < 4; b++) begin
						if (wmask[b])
							dmem[idx][8*b +: 8] = wdata[8*b +: 8];
					end
				end else begin
					rdata_b = dmem[idx];
				end
			end
		end
	endtask

	initial begin
		seed = 49967;
		reset = 1'b1;
		resp_a = 1'b0;
		resp_b = 1'b0;
		rdata_a = '0;
		rdata_b = '0;
		wait_a = 0;
		wait_b = 0;
		next_store = 0;
		idle = 0;
		for (int i = 0; i < 256; i++)
			cases_mem[i] = '0;
		$readmemh("verif/program_cases.mem", cases_mem);
		for (int i = 0; i < 128; i++)
			imem[i] = cases_mem[i];
		// Two preloaded words and an address pattern for the rest
		for (int i = 0; i < 64; i++)
			dmem[i] = (i < 2) ? cases_mem['h80 + i] : 32'hc0de_0000 ^ (dmem_base + 4 * i);
		n_stores = cases_mem[store_list];
		if (n_stores == 0)
			give_up("program_cases.mem holds no expected stores");

		for (int i = 0; i < 16; i++) begin
			@(negedge clk);
			check(read_b, 1'b0, "read_b during reset");
			check(write, 1'b0, "write during reset");
		end
		reset = 1'b0;
		check(read_a, 1'b1, "read_a after reset");
		check(address_a, start_pc, "first fetch address");

		while (next_store < n_stores) begin
			serve_fetch();
			serve_data();
			idle++;
			if (idle > store_timeout)
				give_up($sformatf("store %0d to address %h never came", next_store,
					cases_mem[store_list + 1 + 3 * next_store]));
			@(negedge clk);
		end

		// Program now spins and must not store again
		for (int i = 0; i < 40; i++) begin
			serve_fetch();
			serve_data();
			@(negedge clk);
		end
		$display("PASS: all tests");
		$finish;
	end

endmodule

/* verif/program_cases.mem */
// @00 program words, @80 preloaded data words at 0x200 onward
// @a0 store count, then one expected store per line: address data wmask
@00
20000093 // addi x1, x0, 0x200
12345137 // lui x2, 0x12345
67810193 // addi x3, x2, 0x678
00318233 // add x4, x3, x3
402202B3 // sub x5, x4, x2
FFF2C313 // xori x6, x5, -1
40435393 // srai x7, x6, 4
01C35413 // srli x8, x6, 28
0083A4B3 // slt x9, x7, x8
0083B533 // sltu x10, x7, x8
00540013 // addi x0, x8, 5
008005B3 // add x11, x0, x8
0450A023 // sw x5, 0x40(x1)
0470A223 // sw x7, 0x44(x1)
0490A423 // sw x9, 0x48(x1)
04A0A623 // sw x10, 0x4c(x1)
04B0A823 // sw x11, 0x50(x1)
0000A603 // lw x12, 0(x1)
01160693 // addi x13, x12, 0x11
04D0AA23 // sw x13, 0x54(x1)
00948463 // beq x9, x9, +8
0E70AE23 // sw x7, 0xfc(x1), squashed
00A48463 // beq x9, x10, +8
00170713 // addi x14, x14, 1
00A49463 // bne x9, x10, +8
0E70AE23
00949463 // bne x9, x9, +8
00170713
0083C463 // blt x7, x8, +8
0E70AE23
00744463 // blt x8, x7, +8
00170713
00745463 // bge x8, x7, +8
0E70AE23
0083D463 // bge x7, x8, +8
00170713
00746463 // bltu x8, x7, +8
0E70AE23
0083E463 // bltu x7, x8, +8
00170713
0083F463 // bgeu x7, x8, +8
0E70AE23
00747463 // bgeu x8, x7, +8
00170713
04E0AC23 // sw x14, 0x58(x1)
008007EF // jal x15, +8
0E70AE23
0CC00813 // addi x16, x0, 0xcc
000808E7 // jalr x17, 0(x16)
0E70AE23
0E70AE23
04F0AE23 // sw x15, 0x5c(x1)
0710A023 // sw x17, 0x60(x1)
00408903 // lb x18, 4(x1)
0060C983 // lbu x19, 6(x1)
00609A03 // lh x20, 6(x1)
0040DA83 // lhu x21, 4(x1)
0720A223 // sw x18, 0x64(x1)
0730A423 // sw x19, 0x68(x1)
0740A623 // sw x20, 0x6c(x1)
0750A823 // sw x21, 0x70(x1)
06D08A23 // sb x13, 0x74(x1)
06D08AA3 // sb x13, 0x75(x1)
06D08B23 // sb x13, 0x76(x1)
06D08BA3 // sb x13, 0x77(x1)
06D09C23 // sh x13, 0x78(x1)
06D09D23 // sh x13, 0x7a(x1)
0740AB03 // lw x22, 0x74(x1)
0780AB83 // lw x23, 0x78(x1)
0760AE23 // sw x22, 0x7c(x1)
0970A023 // sw x23, 0x80(x1)
0000006F // jal x0, 0
@80
12345678
80F17F82
@a0
00000015
00000240 12345CF0 F
00000244 FEDCBA30 F
00000248 00000001 F
0000024C 00000000 F
00000250 0000000E F
00000254 12345689 F
00000258 00000006 F
0000025C 000000B8 F
00000260 000000C4 F
00000264 FFFFFF82 F
00000268 000000F1 F
0000026C FFFF80F1 F
00000270 00007F82 F
00000274 00000089 1
00000274 00008900 2
00000274 00890000 4
00000274 89000000 8
00000278 00005689 3
00000278 56890000 C
0000027C 89898989 F
00000280 56895689 F
